//--- hdl/rv32i_pkg.sv
package rv32i_pkg;

  // Memory geometry and reset address
  localparam int MEM_WORDS = 256; // Depth in 32-bit words

  typedef logic [31:0] word_t;                      // Data, addresses and instructions
  typedef logic [4:0]  reg_addr_t;                  // Register index
  typedef logic [$clog2(MEM_WORDS)-1:0] mem_index_t; // Word index into memory

  localparam word_t PC_RESET = 32'h0000_0000; // Byte address of the first fetch

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // Immediate formats
  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_format_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // Controller states
  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEM_ADDR,
    S_MEM_WAIT,
    S_WRITEBACK,
    S_HALT
  } core_state_t;

endpackage

//--- hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic                 clk,
  input  rv32i_pkg::reg_addr_t rd_addr0,
  input  rv32i_pkg::reg_addr_t rd_addr1,
  output rv32i_pkg::word_t     rd_data0,
  output rv32i_pkg::word_t     rd_data1,
  input  logic                 wr_ena,
  input  rv32i_pkg::reg_addr_t wr_addr,
  input  rv32i_pkg::word_t     wr_data
);

  rv32i_pkg::word_t regs [32];

  // Entry 0 is never written
  always_ff @(posedge clk) begin
    if (wr_ena && (wr_addr != 5'd0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 reads as zero
  assign rd_data0 = (rd_addr0 == 5'd0) ? '0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == 5'd0) ? '0 : regs[rd_addr1];

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu (
  input  rv32i_pkg::word_t   a,
  input  rv32i_pkg::word_t   b,
  input  rv32i_pkg::alu_op_t op,
  output rv32i_pkg::word_t   result,
  output logic               equal
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // Only the low five bits shift

  always_comb begin
    case (op)
      rv32i_pkg::ALU_ADD:  result = a + b;
      rv32i_pkg::ALU_SUB:  result = a - b;
      rv32i_pkg::ALU_SLL:  result = a << shamt;
      rv32i_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      rv32i_pkg::ALU_SLTU: result = {31'd0, a < b};
      rv32i_pkg::ALU_XOR:  result = a ^ b;
      rv32i_pkg::ALU_SRL:  result = a >> shamt;
      rv32i_pkg::ALU_SRA:  result = $signed(a) >>> shamt; // Sign bit fills from the left
      rv32i_pkg::ALU_OR:   result = a | b;
      rv32i_pkg::ALU_AND:  result = a & b;
      default:             result = '0;
    endcase
  end

  // BEQ and BNE decision
  assign equal = (a == b);

endmodule

//--- hdl/immediate_extender.sv
`timescale 1ns/10ps

module immediate_extender (
  input  rv32i_pkg::word_t       instruction,
  input  rv32i_pkg::imm_format_t format,
  output rv32i_pkg::word_t       imm
);

  logic sign;

  assign sign = instruction[31]; // Every format takes its sign from bit 31

  always_comb begin
    case (format)
      rv32i_pkg::IMM_I: imm = {{20{sign}}, instruction[31:20]};
      rv32i_pkg::IMM_S: imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
      // Branch offsets are in halfwords
      rv32i_pkg::IMM_B: imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                               instruction[11:8], 1'b0};
      rv32i_pkg::IMM_U: imm = {instruction[31:12], 12'd0}; // Upper twenty bits
      rv32i_pkg::IMM_J: imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                               instruction[30:21], 1'b0};
      default:          imm = '0;
    endcase
  end

endmodule

//--- hdl/rv32i_multicycle_core.sv
`timescale 1ns/10ps

module rv32i_multicycle_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ena,
  output rv32i_pkg::word_t     mem_addr,
  output rv32i_pkg::word_t     mem_wr_data,
  output logic                 mem_wr_ena,
  input  rv32i_pkg::word_t     mem_rd_data,
  output logic                 retire_ena,
  output rv32i_pkg::reg_addr_t retire_rd,
  output rv32i_pkg::word_t     retire_data,
  output logic                 halted
);

  rv32i_pkg::core_state_t state;
  rv32i_pkg::core_state_t state_next;

  // Architectural and internal registers
  rv32i_pkg::word_t pc;
  rv32i_pkg::word_t instr;
  rv32i_pkg::word_t op_a;
  rv32i_pkg::word_t op_b;
  rv32i_pkg::word_t alu_result;
  rv32i_pkg::word_t load_data;
  logic             branch_taken;

  rv32i_pkg::word_t pc_plus4;
  rv32i_pkg::word_t pc_target;
  rv32i_pkg::word_t rf_rd_data0;
  rv32i_pkg::word_t rf_rd_data1;
  rv32i_pkg::word_t wb_data;
  rv32i_pkg::word_t imm;
  rv32i_pkg::word_t alu_a;
  rv32i_pkg::word_t alu_b;
  rv32i_pkg::word_t alu_out;
  logic             alu_equal;

  rv32i_pkg::alu_op_t     alu_op;
  rv32i_pkg::imm_format_t imm_format;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_alt;
  logic       is_r;
  logic       is_i;
  logic       is_load;
  logic       is_store;
  logic       is_branch;
  logic       is_lui;
  logic       is_jal;
  logic       supported;
  logic       writes_rd;
  logic       take_target;

  // Decode from the latched instruction
  assign opcode     = instr[6:0];
  assign funct3     = instr[14:12];
  assign funct7_alt = instr[30]; // SUB and SRA select

  assign is_r      = (opcode == rv32i_pkg::OP_R);
  assign is_i      = (opcode == rv32i_pkg::OP_I);
  assign is_load   = (opcode == rv32i_pkg::OP_LOAD);
  assign is_store  = (opcode == rv32i_pkg::OP_STORE);
  assign is_branch = (opcode == rv32i_pkg::OP_BRANCH);
  assign is_lui    = (opcode == rv32i_pkg::OP_LUI);
  assign is_jal    = (opcode == rv32i_pkg::OP_JAL);

  // Anything outside the subset halts, ECALL included
  assign supported = is_r | is_i | is_load | is_store | is_lui | is_jal |
                     (is_branch & ((funct3 == rv32i_pkg::F3_BEQ) |
                                   (funct3 == rv32i_pkg::F3_BNE)));
  assign writes_rd = is_r | is_i | is_load | is_lui | is_jal;

  always_comb begin
    alu_op = rv32i_pkg::ALU_ADD; // Address and LUI sums
    if (is_r || is_i) begin
      case (funct3)
        3'b000:  alu_op = (is_r && funct7_alt) ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
        3'b001:  alu_op = rv32i_pkg::ALU_SLL;
        3'b010:  alu_op = rv32i_pkg::ALU_SLT;
        3'b011:  alu_op = rv32i_pkg::ALU_SLTU;
        3'b100:  alu_op = rv32i_pkg::ALU_XOR;
        3'b101:  alu_op = funct7_alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
        3'b110:  alu_op = rv32i_pkg::ALU_OR;
        default: alu_op = rv32i_pkg::ALU_AND;
      endcase
    end
  end

  always_comb begin
    case (opcode)
      rv32i_pkg::OP_STORE:  imm_format = rv32i_pkg::IMM_S;
      rv32i_pkg::OP_BRANCH: imm_format = rv32i_pkg::IMM_B;
      rv32i_pkg::OP_LUI:    imm_format = rv32i_pkg::IMM_U;
      rv32i_pkg::OP_JAL:    imm_format = rv32i_pkg::IMM_J;
      default:              imm_format = rv32i_pkg::IMM_I;
    endcase
  end

  // LUI adds its immediate to zero
  assign alu_a = is_lui ? '0 : op_a;
  assign alu_b = (is_r || is_branch) ? op_b : imm;

  assign pc_plus4    = pc + 32'd4;
  assign pc_target   = pc + imm; // Branch and jump destination
  assign take_target = is_jal | (is_branch & branch_taken);

  always_comb begin
    if (is_load) begin
      wb_data = load_data;
    end else if (is_jal) begin
      wb_data = pc_plus4; // Link address
    end else begin
      wb_data = alu_result;
    end
  end

  always_comb begin
    case (state)
      rv32i_pkg::S_FETCH:  state_next = rv32i_pkg::S_DECODE;
      rv32i_pkg::S_DECODE: state_next = rv32i_pkg::S_EXECUTE;
      rv32i_pkg::S_EXECUTE: begin
        if (!supported) begin
          state_next = rv32i_pkg::S_HALT;
        end else if (is_load || is_store) begin
          state_next = rv32i_pkg::S_MEM_ADDR;
        end else begin
          state_next = rv32i_pkg::S_WRITEBACK;
        end
      end
      rv32i_pkg::S_MEM_ADDR:
        state_next = is_load ? rv32i_pkg::S_MEM_WAIT : rv32i_pkg::S_WRITEBACK;
      rv32i_pkg::S_MEM_WAIT:  state_next = rv32i_pkg::S_WRITEBACK;
      rv32i_pkg::S_WRITEBACK: state_next = rv32i_pkg::S_FETCH;
      default:                state_next = rv32i_pkg::S_HALT; // Stays until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv32i_pkg::S_FETCH;
      pc    <= rv32i_pkg::PC_RESET;
    end else if (ena) begin
      state <= state_next;
      if (state == rv32i_pkg::S_WRITEBACK) begin
        pc <= take_target ? pc_target : pc_plus4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ena) begin
      case (state)
        rv32i_pkg::S_DECODE: begin
          instr <= mem_rd_data; // Fetched word arrives now
          op_a  <= rf_rd_data0;
          op_b  <= rf_rd_data1;
        end
        rv32i_pkg::S_EXECUTE: begin
          alu_result   <= alu_out;
          branch_taken <= (funct3 == rv32i_pkg::F3_BNE) ? ~alu_equal : alu_equal;
        end
        rv32i_pkg::S_MEM_WAIT: load_data <= mem_rd_data;
        default: ;
      endcase
    end
  end

  // Data address held through the load wait
  assign mem_addr = ((state == rv32i_pkg::S_MEM_ADDR) || (state == rv32i_pkg::S_MEM_WAIT)) ?
                    alu_result : pc;
  assign mem_wr_data = op_b;
  assign mem_wr_ena  = ena && (state == rv32i_pkg::S_MEM_ADDR) && is_store;

  assign retire_ena  = ena && (state == rv32i_pkg::S_WRITEBACK) && writes_rd &&
                       (instr[11:7] != 5'd0);
  assign retire_rd   = instr[11:7];
  assign retire_data = wb_data;
  assign halted      = (state == rv32i_pkg::S_HALT);

  // Source fields come straight from memory during decode
  register_file register_file_inst (
    .clk      (clk),
    .rd_addr0 (mem_rd_data[19:15]),
    .rd_addr1 (mem_rd_data[24:20]),
    .rd_data0 (rf_rd_data0),
    .rd_data1 (rf_rd_data1),
    .wr_ena   (retire_ena),
    .wr_addr  (retire_rd),
    .wr_data  (wb_data)
  );

  alu alu_inst (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_out),
    .equal  (alu_equal)
  );

  immediate_extender immediate_extender_inst (
    .instruction (instr),
    .format      (imm_format),
    .imm         (imm)
  );

endmodule

//--- hdl/unified_memory.sv
`timescale 1ns/10ps

module unified_memory (
  input  logic                  clk,
  input  rv32i_pkg::mem_index_t addr,
  input  rv32i_pkg::word_t      wr_data,
  input  logic                  wr_ena,
  output rv32i_pkg::word_t      rd_data,
  input  logic                  load_ena,
  input  rv32i_pkg::mem_index_t load_addr,
  input  rv32i_pkg::word_t      load_data
);

  rv32i_pkg::word_t mem [rv32i_pkg::MEM_WORDS];

  // Program load wins over a core store
  always_ff @(posedge clk) begin
    if (load_ena) begin
      mem[load_addr] <= load_data;
    end else if (wr_ena) begin
      mem[addr] <= wr_data;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    rd_data <= mem[addr];
  end

endmodule

//--- hdl/rv32i_system.sv
`timescale 1ns/10ps

module rv32i_system (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ena,
  input  logic                  load_ena,
  input  rv32i_pkg::mem_index_t load_addr,
  input  rv32i_pkg::word_t      load_data,
  output logic                  retire_ena,
  output rv32i_pkg::reg_addr_t  retire_rd,
  output rv32i_pkg::word_t      retire_data,
  output logic                  mem_wr_ena,
  output rv32i_pkg::word_t      mem_addr,
  output rv32i_pkg::word_t      mem_wr_data,
  output logic                  halted
);

  rv32i_pkg::word_t mem_rd_data;

  rv32i_multicycle_core rv32i_multicycle_core_inst (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_ena  (mem_wr_ena),
    .mem_rd_data (mem_rd_data),
    .retire_ena  (retire_ena),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .halted      (halted)
  );

  unified_memory unified_memory_inst (
    .clk       (clk),
    .addr      (mem_addr[9:2]), // Byte address to word index
    .wr_data   (mem_wr_data),
    .wr_ena    (mem_wr_ena),
    .rd_data   (mem_rd_data),
    .load_ena  (load_ena),
    .load_addr (load_addr),
    .load_data (load_data)
  );

endmodule

//--- bench/tb_rv32i_system.sv
`timescale 1ns/10ps

module tb_rv32i_system;

  logic                  clk;
  logic                  rst;
  logic                  ena;
  logic                  load_ena;
  rv32i_pkg::mem_index_t load_addr;
  rv32i_pkg::word_t      load_data;
  logic                  retire_ena;
  rv32i_pkg::reg_addr_t  retire_rd;
  rv32i_pkg::word_t      retire_data;
  logic                  mem_wr_ena;
  rv32i_pkg::word_t      mem_addr;
  rv32i_pkg::word_t      mem_wr_data;
  logic                  halted;

  rv32i_pkg::word_t prog [$];     // Assembled program
  rv32i_pkg::word_t image [256];  // Model memory image
  logic [36:0]      retire_q [$]; // {rd, data} in program order
  logic [63:0]      store_q [$];  // {address, data}
  logic [36:0]      retire_exp;
  logic [63:0]      store_exp;
  bit               program_ready;
  bit               running;
  int               value_errors;
  int               event_errors;
  int               end_errors;

  // funct3 and instruction bit 30 of the ten ALU operations in enum order
  logic [2:0] op_f3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic       op_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

  rv32i_system rv32i_system_inst (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .load_ena    (load_ena),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .retire_ena  (retire_ena),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .mem_wr_ena  (mem_wr_ena),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .halted      (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic rv32i_pkg::word_t r_type(input logic alt, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv32i_pkg::OP_R};
  endfunction

  function automatic rv32i_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32i_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv32i_pkg::OP_STORE}; // SW
  endfunction

  function automatic rv32i_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32i_pkg::OP_BRANCH};
  endfunction

  function automatic rv32i_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv32i_pkg::OP_JAL};
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(15, 0)); // x16 stays the data base
  endfunction

  // Never x0 so the write shows up as a retire
  function automatic logic [4:0] pick_dest();
    return 5'($urandom_range(15, 1));
  endfunction

  // Expected result of an RV32I ALU operation
  function automatic rv32i_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                 input rv32i_pkg::word_t a,
                                                 input rv32i_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? rv32i_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic build_program();
    logic [11:0] imm;
    logic [6:0]  off;
    logic [4:0]  rs;
    int          n;
    int          k;
    for (n = 1; n < 16; n++) begin // Random values in x1 to x15
      prog.push_back({20'($urandom), 5'(n), rv32i_pkg::OP_LUI});
      prog.push_back(i_type(12'($urandom), 5'(n), 3'd0, 5'(n), rv32i_pkg::OP_I));
    end
    prog.push_back(i_type(12'h200, 5'd0, 3'd0, 5'd16, rv32i_pkg::OP_I)); // Data area base
    for (n = 0; n < 20; n++) begin
      k = n % 10;
      prog.push_back(r_type(op_alt[k], pick_reg(), pick_reg(), op_f3[k], pick_reg()));
      if (k != 1) begin
        // Shifts carry a five bit amount and the SRAI marker
        imm = (op_f3[k] == 3'd1 || op_f3[k] == 3'd5) ? {1'b0, op_alt[k], 5'd0, 5'($urandom)}
                                                      : 12'($urandom);
        prog.push_back(i_type(imm, pick_reg(), op_f3[k], pick_reg(), rv32i_pkg::OP_I));
      end
    end
    prog.push_back(r_type(1'b0, pick_reg(), pick_reg(), 3'd0, 5'd0)); // Write to x0
    prog.push_back(i_type(12'($urandom), 5'd0, 3'd0, pick_dest(), rv32i_pkg::OP_I));
    for (n = 0; n < 4; n++) begin
      off = 7'($urandom_range(31, 0) * 4);
      prog.push_back(s_type({5'd0, off}, pick_reg(), 5'd16));
      prog.push_back(i_type({5'd0, off}, 5'd16, 3'b010, pick_dest(), rv32i_pkg::OP_LOAD));
    end
    for (n = 0; n < 4; n++) begin
      rs = pick_reg();
      // Equal operands first, then against the data base
      prog.push_back(b_type(13'd8, (n < 2) ? rs : 5'd16, rs,
                            n[0] ? rv32i_pkg::F3_BNE : rv32i_pkg::F3_BEQ));
      prog.push_back(r_type(1'b0, pick_reg(), pick_reg(), 3'd0, pick_dest())); // Maybe skipped
    end
    prog.push_back(j_type(21'd8, pick_dest()));
    prog.push_back(r_type(1'b0, pick_reg(), pick_reg(), 3'd0, pick_dest())); // Jumped over
    prog.push_back({20'($urandom), pick_dest(), rv32i_pkg::OP_LUI});
    prog.push_back(32'h0000_0073); // ECALL
    prog.push_back(r_type(1'b0, pick_reg(), pick_reg(), 3'd0, pick_dest()));
  endtask

  // Executes the program and queues every expected retire and store
  task automatic run_model();
    rv32i_pkg::word_t regs [32];
    rv32i_pkg::word_t pc;
    rv32i_pkg::word_t ins;
    rv32i_pkg::word_t res;
    rv32i_pkg::word_t addr;
    rv32i_pkg::word_t next_pc;
    logic             writes;
    logic             stop;
    int               i;
    for (i = 0; i < 256; i++) image[i] = (i < prog.size()) ? prog[i] : '0;
    for (i = 0; i < 32; i++) regs[i] = '0;
    pc = rv32i_pkg::PC_RESET;
    stop = 1'b0;
    while (!stop) begin
      ins = image[pc[9:2]];
      writes = 1'b1;
      next_pc = pc + 4;
      res = '0;
      case (ins[6:0])
        rv32i_pkg::OP_R: res = alu_model(ins[14:12], ins[30], regs[ins[19:15]], regs[ins[24:20]]);
        rv32i_pkg::OP_I: res = alu_model(ins[14:12], ins[30] && (ins[14:12] == 3'd5),
                                         regs[ins[19:15]], {{20{ins[31]}}, ins[31:20]});
        rv32i_pkg::OP_LOAD: begin
          addr = regs[ins[19:15]] + {{20{ins[31]}}, ins[31:20]};
          res = image[addr[9:2]];
        end
        rv32i_pkg::OP_STORE: begin
          addr = regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          image[addr[9:2]] = regs[ins[24:20]];
          store_q.push_back({addr, regs[ins[24:20]]});
          writes = 1'b0;
        end
        rv32i_pkg::OP_BRANCH: begin
          if ((regs[ins[19:15]] == regs[ins[24:20]]) != (ins[14:12] == rv32i_pkg::F3_BNE))
            next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          writes = 1'b0;
        end
        rv32i_pkg::OP_LUI: res = {ins[31:12], 12'd0};
        rv32i_pkg::OP_JAL: begin
          res = pc + 4;
          next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: begin
          stop = 1'b1; // ECALL ends the program
          writes = 1'b0;
        end
      endcase
      if (writes && ins[11:7] != 5'd0) begin
        regs[ins[11:7]] = res;
        retire_q.push_back({ins[11:7], res});
      end
      pc = next_pc;
    end
  endtask

  // Outputs settle between edges
  always @(negedge clk) begin
    if (!rst) begin
      if (!running) begin
        assert (!retire_ena && !mem_wr_ena && !halted) else begin
          event_errors++;
          $display("Core became active before it was enabled");
        end
      end
      if (!ena || halted) begin
        assert (!retire_ena && !mem_wr_ena) else begin
          event_errors++;
          $display("Retire or store while the core was paused or halted");
        end
      end
      if (retire_ena) begin
        assert (retire_q.size() != 0) else begin
          event_errors++;
          $display("Retire of x%0d with no retire left to expect", retire_rd);
        end
        if (retire_q.size() != 0) begin
          retire_exp = retire_q.pop_front();
          assert (retire_rd == retire_exp[36:32]) else begin
            value_errors++;
            $display("Error: retire_rd expected %h got %h", retire_exp[36:32], retire_rd);
          end
          assert (retire_data == retire_exp[31:0]) else begin
            value_errors++;
            $display("Error: retire_data expected %h got %h", retire_exp[31:0], retire_data);
          end
        end
      end
      if (mem_wr_ena) begin
        assert (store_q.size() != 0) else begin
          event_errors++;
          $display("Store with no store left to expect");
        end
        if (store_q.size() != 0) begin
          store_exp = store_q.pop_front();
          assert (mem_addr == store_exp[63:32]) else begin
            value_errors++;
            $display("Error: mem_addr expected %h got %h", store_exp[63:32], mem_addr);
          end
          assert (mem_wr_data == store_exp[31:0]) else begin
            value_errors++;
            $display("Error: mem_wr_data expected %h got %h", store_exp[31:0], mem_wr_data);
          end
        end
      end
    end
  end

  initial begin
    int i;
    void'($urandom(32'hbc5a));
    rst       <= 1'b1;
    ena       <= 1'b0;
    load_ena  <= 1'b0;
    load_addr <= '0;
    load_data <= '0;
    build_program();
    run_model();
    program_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk); // Idle after reset with ena low
    for (i = 0; i < prog.size(); i++) begin
      load_ena  <= 1'b1;
      load_addr <= 8'(i);
      load_data <= prog[i];
      @(posedge clk);
    end
    load_ena <= 1'b0;
    ena      <= 1'b1;
    running = 1'b1;
    do begin
      @(posedge clk);
      ena <= ($urandom_range(15, 0) != 0); // Occasional pauses
      @(negedge clk);
    end while (!halted);
    @(posedge clk);
    ena <= 1'b1;
    repeat (6) @(posedge clk); // Nothing may follow the halt
    assert (retire_q.size() == 0 && store_q.size() == 0) else begin
      end_errors++;
      $display("Halted with %0d retires and %0d stores still expected",
               retire_q.size(), store_q.size());
    end
    $display("Errors: %0d wrong values, %0d unexpected events, %0d missing events",
             value_errors, event_errors, end_errors);
    if (value_errors + event_errors + end_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Worst case six clocks per instruction plus load, pauses and margin
  initial begin
    wait (program_ready);
    #((12 * prog.size() + 400) * 100);
    $display("Timeout: the core did not reach its halt in time");
    $display("Something failed");
    $finish;
  end

endmodule

//--- verilog.f
hdl/rv32i_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/immediate_extender.sv
hdl/rv32i_multicycle_core.sv
hdl/unified_memory.sv
hdl/rv32i_system.sv
bench/tb_rv32i_system.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module tb_rv32i_system

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_rv32i_system -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
